// ==== design/fm_defs.svh ====
// ----------------------------------------
// fixed values of the FM register front end
// register addresses, channel count, busy length and
// timer B prescaler; include where a module needs them
// ----------------------------------------
`ifndef FM_DEFS_SVH
`define FM_DEFS_SVH

`define FM_NUM_CH        6

// global registers
`define FM_REG_LFO       8'h22
`define FM_REG_CLKA1     8'h24
`define FM_REG_CLKA2     8'h25
`define FM_REG_CLKB      8'h26
`define FM_REG_TIMER     8'h27
`define FM_REG_KON       8'h28
`define FM_REG_CLK_N6    8'h2D
`define FM_REG_CLK_N3    8'h2E
`define FM_REG_CLK_N2    8'h2F

// channel register bases, low two bits give the channel
`define FM_REG_FNUM_LO   8'hA0
`define FM_REG_FNUM_HI   8'hA4
`define FM_REG_ALG       8'hB0

`define FM_BUSY_LEN      32   // clk_en pulses
`define FM_TB_PRESCALE   16   // clk_en pulses per timer B step

`endif

// ==== design/fm_pkg.sv ====
// ----------------------------------------
// vector types of the FM register front end
// shared by the RTL and the testbench
// ----------------------------------------
package fm_pkg;

    typedef logic [7:0]  reg_addr_t;  // selected register
    typedef logic [7:0]  reg_data_t;  // host data byte
    typedef logic [2:0]  chan_t;      // bank in bit 2, channel in bits 1..0
    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;
    typedef logic [2:0]  alg_t;
    typedef logic [2:0]  fb_t;
    typedef logic [9:0]  timer_a_t;
    typedef logic [7:0]  timer_b_t;
    typedef logic [1:0]  div_sel_t;   // 10 -> /6, 11 -> /3, 0x -> /2

    // channel 3 within a bank does not exist
    function automatic logic chan_valid(input chan_t ch);
        return ch[1:0] != 2'b11;
    endfunction

    // linear index 0..5 of a banked channel number
    function automatic chan_t chan_idx(input chan_t ch);
        chan_t base;
        base = {1'b0, ch[1:0]};
        return ch[2] ? base + 3'd3 : base;
    endfunction

endpackage

// ==== design/fm_clk_div.sv ====
// ----------------------------------------
// synthesizer clock enable from the host cen
// divides cen pulses by 6, 3 or 2 as div_sel says
// ----------------------------------------
`timescale 1ns/1ps

module fm_clk_div (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  fm_pkg::div_sel_t div_sel,
    output logic             clk_en
);
    import fm_pkg::*;

    logic [2:0] cen_cnt;
    logic [2:0] last;       // wrap point of cen_cnt
    div_sel_t   div_sel_q;

    always_comb begin
        case (div_sel)
            2'b10:   last = 3'd5;
            2'b11:   last = 3'd2;
            default: last = 3'd1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt   <= 3'd1;  // no pulse on the first cen out of reset
            div_sel_q <= 2'b10;
        end else begin
            div_sel_q <= div_sel;
            if (div_sel != div_sel_q)
                cen_cnt <= '0;  // new ratio, count again
            else if (cen)
                cen_cnt <= (cen_cnt == last) ? 3'd0 : cen_cnt + 3'd1;
        end
    end

    assign clk_en = cen && (cen_cnt == 3'd0);

endmodule

// ==== design/fm_mmr.sv ====
// ----------------------------------------
// host register decoder
// even address selects a register, odd address writes it;
// drives global fields, channel strobes, busy and div_sel
// ----------------------------------------
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_mmr (
    input  logic              clk,
    input  logic              rst,
    input  fm_pkg::reg_data_t din,
    input  logic              write,
    input  logic [1:0]        addr,
    input  logic              clk_en,
    output logic              busy,
    output fm_pkg::div_sel_t  div_sel,
    output fm_pkg::reg_data_t wr_data,
    output fm_pkg::chan_t     wr_chan,
    output logic              up_fnum_lo,
    output logic              up_fnum_hi,
    output logic              up_alg,
    output fm_pkg::timer_a_t  value_a,
    output fm_pkg::timer_b_t  value_b,
    output logic              load_a,
    output logic              load_b,
    output logic              enable_irq_a,
    output logic              enable_irq_b,
    output logic              clr_flag_a,
    output logic              clr_flag_b,
    output logic [5:0]        keyon,
    output logic              lfo_en,
    output logic [2:0]        lfo_freq
);
    import fm_pkg::*;

    localparam int BUSY_W = $clog2(`FM_BUSY_LEN);

    reg_addr_t         sel_reg;
    reg_addr_t         ch_base;     // channel register with bank bits masked
    logic              ch_ok;
    logic              data_wr;
    logic              write_q;
    logic [BUSY_W-1:0] busy_cnt;

    assign data_wr = write && addr[0];
    assign ch_base = sel_reg & 8'hFC;
    assign ch_ok   = chan_valid(sel_reg[2:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg  <= '0;
            div_sel  <= 2'b10;      // divide by 6
            value_a  <= '0;
            value_b  <= '0;
            {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a, load_b, load_a} <= '0;
            keyon    <= '0;
            lfo_en   <= 1'b0;
            lfo_freq <= '0;
        end else begin
            if (write && !addr[0])
                sel_reg <= din;
            if (data_wr) begin
                case (sel_reg)
                    `FM_REG_LFO:    {lfo_en, lfo_freq} <= din[3:0];
                    `FM_REG_CLKA1:  value_a[9:2] <= din;
                    `FM_REG_CLKA2:  value_a[1:0] <= din[1:0];
                    `FM_REG_CLKB:   value_b <= din;
                    `FM_REG_TIMER: begin
                        {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a,
                         load_b, load_a} <= din[5:0];
                    end
                    `FM_REG_KON: begin
                        // any operator bit set turns the channel on
                        if (chan_valid(din[2:0]))
                            keyon[chan_idx(din[2:0])] <= |din[7:4];
                    end
                    `FM_REG_CLK_N6: div_sel[1] <= 1'b1;
                    `FM_REG_CLK_N3: div_sel[0] <= 1'b1;
                    `FM_REG_CLK_N2: div_sel <= 2'b00;
                    default: ;
                endcase
            end else if (clk_en) begin
                clr_flag_a <= 1'b0; // one-shot clear bits
                clr_flag_b <= 1'b0;
            end
        end
    end

    // channel update strobes, one cycle after the data write
    always_ff @(posedge clk) begin
        if (rst) begin
            up_fnum_lo <= 1'b0;
            up_fnum_hi <= 1'b0;
            up_alg     <= 1'b0;
        end else begin
            up_fnum_lo <= data_wr && ch_ok && (ch_base == `FM_REG_FNUM_LO);
            up_fnum_hi <= data_wr && ch_ok && (ch_base == `FM_REG_FNUM_HI);
            up_alg     <= data_wr && ch_ok && (ch_base == `FM_REG_ALG);
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            wr_data <= din;
            wr_chan <= {addr[1], sel_reg[1:0]};
        end
    end

    // busy runs for FM_BUSY_LEN clk_en pulses after a data write
    always_ff @(posedge clk) begin
        if (rst) begin
            write_q  <= 1'b0;
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else begin
            write_q <= write;
            if (data_wr && !write_q) begin
                busy     <= 1'b1;
                busy_cnt <= '0;
            end else if (clk_en && busy) begin
                if (busy_cnt == BUSY_W'(`FM_BUSY_LEN - 1))
                    busy <= 1'b0;
                busy_cnt <= busy_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/fm_chan_regs.sv ====
// ----------------------------------------
// per-channel fnum, block, algorithm and feedback
// fnum high byte goes through one shared latch;
// combinational read port selected by rd_chan
// ----------------------------------------
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_chan_regs (
    input  logic              clk,
    input  logic              rst,
    input  fm_pkg::reg_data_t wr_data,
    input  fm_pkg::chan_t     wr_chan,
    input  logic              up_fnum_lo,
    input  logic              up_fnum_hi,
    input  logic              up_alg,
    input  fm_pkg::chan_t     rd_chan,
    output fm_pkg::fnum_t     fnum,
    output fm_pkg::block_t    block,
    output fm_pkg::alg_t      alg,
    output fm_pkg::fb_t       fb
);
    import fm_pkg::*;

    logic [5:0] fnum_latch;     // block in 5:3, fnum msbs in 2:0
    fnum_t      fnum_mem  [`FM_NUM_CH];
    block_t     block_mem [`FM_NUM_CH];
    alg_t       alg_mem   [`FM_NUM_CH];
    fb_t        fb_mem    [`FM_NUM_CH];
    chan_t      wr_idx;
    chan_t      rd_idx;
    logic       rd_ok;

    assign wr_idx = chan_idx(wr_chan);
    assign rd_idx = chan_idx(rd_chan);
    assign rd_ok  = chan_valid(rd_chan);

    always_ff @(posedge clk) begin
        if (rst)
            fnum_latch <= '0;
        else if (up_fnum_hi)
            fnum_latch <= wr_data[5:0];
    end

    always_ff @(posedge clk) begin
        if (up_fnum_lo) begin
            block_mem[wr_idx] <= fnum_latch[5:3];
            fnum_mem[wr_idx]  <= {fnum_latch[2:0], wr_data};
        end
        if (up_alg) begin
            fb_mem[wr_idx]  <= wr_data[5:3];
            alg_mem[wr_idx] <= wr_data[2:0];
        end
    end

    // missing channel reads as zero
    assign fnum  = rd_ok ? fnum_mem[rd_idx]  : '0;
    assign block = rd_ok ? block_mem[rd_idx] : '0;
    assign alg   = rd_ok ? alg_mem[rd_idx]   : '0;
    assign fb    = rd_ok ? fb_mem[rd_idx]    : '0;

endmodule

// ==== design/fm_timers.sv ====
// ----------------------------------------
// timers A and B with flags and interrupt
// counters run up to all ones while load is high,
// then reload and set the flag if enabled
// ----------------------------------------
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_timers (
    input  logic             clk,
    input  logic             rst,
    input  logic             clk_en,
    input  fm_pkg::timer_a_t value_a,
    input  fm_pkg::timer_b_t value_b,
    input  logic             load_a,
    input  logic             load_b,
    input  logic             enable_irq_a,
    input  logic             enable_irq_b,
    input  logic             clr_flag_a,
    input  logic             clr_flag_b,
    output logic             flag_a,
    output logic             flag_b,
    output logic             irq_n
);
    import fm_pkg::*;

    localparam int PRE_W = $clog2(`FM_TB_PRESCALE);

    timer_a_t          cnt_a;
    timer_b_t          cnt_b;
    logic [PRE_W-1:0]  pre_b;       // timer B prescaler
    logic              load_a_q, load_b_q;
    logic              run_a, run_b;
    logic              pre_wrap;
    logic              ovf_a, ovf_b;

    assign run_a    = clk_en && load_a && load_a_q;
    assign run_b    = clk_en && load_b && load_b_q;
    assign pre_wrap = pre_b == PRE_W'(`FM_TB_PRESCALE - 1);
    assign ovf_a    = run_a && (&cnt_a);
    assign ovf_b    = run_b && pre_wrap && (&cnt_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a_q <= 1'b0;
            load_b_q <= 1'b0;
            cnt_a    <= '0;
            cnt_b    <= '0;
            pre_b    <= '0;
        end else begin
            load_a_q <= load_a;
            load_b_q <= load_b;
            if ((load_a && !load_a_q) || ovf_a)
                cnt_a <= value_a;
            else if (run_a)
                cnt_a <= cnt_a + 1'b1;
            if (load_b && !load_b_q) begin
                cnt_b <= value_b;
                pre_b <= '0;
            end else if (run_b) begin
                pre_b <= pre_wrap ? '0 : pre_b + 1'b1;
                if (pre_wrap)
                    cnt_b <= ovf_b ? value_b : cnt_b + 1'b1;
            end
        end
    end

    // overflow wins over a pending clear
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ovf_a && enable_irq_a)
                flag_a <= 1'b1;
            else if (clr_flag_a)
                flag_a <= 1'b0;
            if (ovf_b && enable_irq_b)
                flag_b <= 1'b1;
            else if (clr_flag_b)
                flag_b <= 1'b0;
        end
    end

    assign irq_n = !(flag_a || flag_b);

endmodule

// ==== design/fm_top.sv ====
// ----------------------------------------
// FM register front end top level
// divider, register decoder, channel store and timers
// ----------------------------------------
`timescale 1ns/1ps

module fm_top (
    input  logic              clk,
    input  logic              rst,
    input  fm_pkg::reg_data_t din,
    input  logic              write,
    input  logic [1:0]        addr,
    input  logic              cen,
    input  fm_pkg::chan_t     rd_chan,
    output logic              busy,
    output logic              clk_en,
    output logic              flag_a,
    output logic              flag_b,
    output logic              irq_n,
    output logic [5:0]        keyon,
    output logic              lfo_en,
    output logic [2:0]        lfo_freq,
    output fm_pkg::fnum_t     fnum,
    output fm_pkg::block_t    block,
    output fm_pkg::alg_t      alg,
    output fm_pkg::fb_t       fb
);
    import fm_pkg::*;

    div_sel_t  div_sel;
    reg_data_t wr_data;
    chan_t     wr_chan;
    logic      up_fnum_lo, up_fnum_hi, up_alg;
    timer_a_t  value_a;
    timer_b_t  value_b;
    logic      load_a, load_b, enable_irq_a, enable_irq_b;
    logic      clr_flag_a, clr_flag_b;

    fm_clk_div fm_clk_div_inst (
        .clk(clk), .rst(rst), .cen(cen), .div_sel(div_sel), .clk_en(clk_en)
    );

    fm_mmr fm_mmr_inst (
        .clk(clk), .rst(rst), .din(din), .write(write), .addr(addr), .clk_en(clk_en),
        .busy(busy), .div_sel(div_sel), .wr_data(wr_data), .wr_chan(wr_chan),
        .up_fnum_lo(up_fnum_lo), .up_fnum_hi(up_fnum_hi), .up_alg(up_alg),
        .value_a(value_a), .value_b(value_b), .load_a(load_a), .load_b(load_b),
        .enable_irq_a(enable_irq_a), .enable_irq_b(enable_irq_b),
        .clr_flag_a(clr_flag_a), .clr_flag_b(clr_flag_b),
        .keyon(keyon), .lfo_en(lfo_en), .lfo_freq(lfo_freq)
    );

    fm_chan_regs fm_chan_regs_inst (
        .clk(clk), .rst(rst), .wr_data(wr_data), .wr_chan(wr_chan),
        .up_fnum_lo(up_fnum_lo), .up_fnum_hi(up_fnum_hi), .up_alg(up_alg),
        .rd_chan(rd_chan), .fnum(fnum), .block(block), .alg(alg), .fb(fb)
    );

    fm_timers fm_timers_inst (
        .clk(clk), .rst(rst), .clk_en(clk_en),
        .value_a(value_a), .value_b(value_b), .load_a(load_a), .load_b(load_b),
        .enable_irq_a(enable_irq_a), .enable_irq_b(enable_irq_b),
        .clr_flag_a(clr_flag_a), .clr_flag_b(clr_flag_b),
        .flag_a(flag_a), .flag_b(flag_b), .irq_n(irq_n)
    );

endmodule

// ==== tb/fm_tb_clk.sv ====
// ----------------------------------------
// testbench clock, 4 ns period
// ----------------------------------------
`timescale 1ns/1ps

module fm_tb_clk (
    output logic clk
);

    initial clk = 1'b0;

    always #2 clk = !clk;

endmodule

// ==== tb/fm_chk.sv ====
// ----------------------------------------
// concurrent checks on the FM front end ports
// bound into every fm_top instance
// ----------------------------------------
`timescale 1ns/1ps

module fm_chk (
    input logic clk,
    input logic rst,
    input logic cen,
    input logic clk_en,
    input logic busy,
    input logic flag_a,
    input logic flag_b,
    input logic irq_n
);

    logic assert_fail = 1'b0;   // sticky, read by the testbench

    clk_en_needs_cen: assert property (@(posedge clk) disable iff (rst) clk_en |-> cen)
        else begin
            $error("clk_en pulse without cen");
            assert_fail = 1'b1;
        end

    // busy must come out of reset low
    busy_low_after_rst: assert property (@(posedge clk) rst |=> !busy)
        else begin
            $error("busy high in the cycle after reset");
            assert_fail = 1'b1;
        end

    irq_follows_flags: assert property (@(posedge clk) disable iff (rst)
                                        irq_n == !(flag_a || flag_b))
        else begin
            $error("irq_n does not follow the timer flags");
            assert_fail = 1'b1;
        end

endmodule

bind fm_top fm_chk fm_chk_inst (.*);

// ==== tb/fm_tb.sv ====
// ----------------------------------------
// testbench for the FM register front end
// drives host writes, checks divider, channel store,
// busy, key-on, LFO and both timers
// ----------------------------------------
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_tb;
    import fm_pkg::*;

    localparam int       TIMEOUT = 2000;     // cycles per wait
    localparam timer_a_t VAL_A   = 10'd1000;
    localparam timer_b_t VAL_B   = 8'hFD;

    logic       clk;
    logic       rst;
    reg_data_t  din;
    logic       write;
    logic [1:0] addr;
    logic       cen;
    chan_t      rd_chan;
    logic       busy, clk_en, flag_a, flag_b, irq_n;
    logic [5:0] keyon;
    logic       lfo_en;
    logic [2:0] lfo_freq;
    fnum_t      fnum;
    block_t     block;
    alg_t       alg;
    fb_t        fb;

    logic [31:0] seed;
    logic [5:0]  kexp;      // expected key-on bits
    fnum_t       f_exp  [6];
    block_t      b_exp  [6];
    alg_t        a_exp  [6];
    fb_t         fb_exp [6];

    fm_tb_clk fm_tb_clk_inst (.clk(clk));

    fm_top fm_top_inst (.*);

    always @(posedge clk) cen <= #1 !cen;   // high on every second clk

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("Mismatch %s expected %0h actual %0h", name, expected, actual));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // linear channel 0..5 to bank and channel code
    function automatic chan_t chan_code(input int c);
        return (c < 3) ? chan_t'(c) : chan_t'(c + 1);
    endfunction

    task automatic write_reg(input logic bank, input reg_addr_t sel, input reg_data_t data);
        @(posedge clk);
        #1;
        write = 1'b1;
        addr  = {bank, 1'b0};
        din   = sel;
        @(posedge clk);
        #1;
        write = 1'b0;   // idle cycle
        @(posedge clk);
        #1;
        write = 1'b1;
        addr  = {bank, 1'b1};
        din   = data;
        @(posedge clk);
        #1;
        write = 1'b0;
    endtask

    // cen pulses from one clk_en up to the next
    task automatic measure_div(input int expected, input string name);
        int n;
        int i;
        n = 0;
        repeat (2) @(posedge clk);
        for (i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (clk_en)
                break;
        end
        if (!clk_en)
            fail_run("no clk_en pulse from the divider");
        for (i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (cen)
                n++;
            if (clk_en)
                break;
        end
        if (!clk_en)
            fail_run("divider stopped pulsing clk_en");
        check(name, expected, n);
    endtask

    task automatic busy_test;
        int n;
        int i;
        n = 0;
        for (i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (!busy)
                break;
        end
        if (busy)
            fail_run("busy stuck high before the busy test");
        write_reg(1'b0, `FM_REG_LFO, 8'h0D);
        @(negedge clk);
        check("busy rise", 1, busy);
        for (i = 0; i < TIMEOUT && busy; i++) begin
            if (clk_en)
                n++;
            @(negedge clk);
        end
        if (busy)
            fail_run("busy did not return low");
        check("busy length", `FM_BUSY_LEN, n);
        check("lfo_en", 1, lfo_en);
        check("lfo_freq", 5, lfo_freq);
    endtask

    task automatic check_chan(input int c);
        @(posedge clk);
        #1;
        rd_chan = chan_code(c);
        @(posedge clk);
        @(negedge clk);
        check($sformatf("fnum ch%0d", c), f_exp[c], fnum);
        check($sformatf("block ch%0d", c), b_exp[c], block);
        check($sformatf("alg ch%0d", c), a_exp[c], alg);
        check($sformatf("fb ch%0d", c), fb_exp[c], fb);
    endtask

    task automatic chan_store_test;
        int        c;
        chan_t     code;
        reg_data_t lo;
        for (c = 0; c < 6; c++) begin
            code      = chan_code(c);
            seed      = xorshift(seed);
            f_exp[c]  = seed[10:0];
            b_exp[c]  = seed[13:11];
            a_exp[c]  = seed[16:14];
            fb_exp[c] = seed[19:17];
            write_reg(code[2], `FM_REG_FNUM_HI + code[1:0], {2'b00, b_exp[c], f_exp[c][10:8]});
            write_reg(code[2], `FM_REG_FNUM_LO + code[1:0], f_exp[c][7:0]);
            write_reg(code[2], `FM_REG_ALG + code[1:0], {2'b00, fb_exp[c], a_exp[c]});
        end
        for (c = 0; c < 6; c++)
            check_chan(c);
        // lone low byte takes the high latch of the last channel
        seed = xorshift(seed);
        lo   = seed[7:0];
        write_reg(1'b0, `FM_REG_FNUM_LO, lo);
        f_exp[0] = {f_exp[5][10:8], lo};
        b_exp[0] = b_exp[5];
        check_chan(0);
    endtask

    task automatic key_write(input int c, input logic [3:0] ops);
        write_reg(1'b0, `FM_REG_KON, {ops, 1'b0, chan_code(c)});
        kexp[c] = |ops;
        @(negedge clk);
        check($sformatf("keyon ch%0d", c), kexp, keyon);
    endtask

    // clk_en pulses between two flag rises, cleared in between
    task automatic timer_period(input logic sel_b, input reg_data_t clr_cmd,
                                input int expected, input string name);
        int   n;
        int   i;
        logic seen_low;
        n        = 0;
        seen_low = 1'b0;
        for (i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (sel_b ? flag_b : flag_a)
                break;
        end
        if (!(sel_b ? flag_b : flag_a))
            fail_run("timer flag never set");
        check({name, " irq_n"}, 0, irq_n);
        fork
            begin
                for (i = 0; i < TIMEOUT; i++) begin
                    if (clk_en)
                        n++;
                    @(negedge clk);
                    if (!(sel_b ? flag_b : flag_a))
                        seen_low = 1'b1;
                    else if (seen_low)
                        break;
                end
            end
            write_reg(1'b0, `FM_REG_TIMER, clr_cmd);
        join
        if (!seen_low || !(sel_b ? flag_b : flag_a))
            fail_run("timer flag did not clear and set again");
        check(name, expected, n);
    endtask

    always @(negedge clk) begin
        if (fm_top_inst.fm_chk_inst.assert_fail)
            fail_run("a bound port assertion failed");
    end

    initial begin
        int i;
        rst     = 1'b1;
        din     = '0;
        write   = 1'b0;
        addr    = '0;
        cen     = 1'b0;
        rd_chan = '0;
        seed    = 32'h4554;
        kexp    = '0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        measure_div(6, "div after reset");
        write_reg(1'b0, `FM_REG_CLK_N6, 8'h00);
        write_reg(1'b0, `FM_REG_CLK_N3, 8'h00);
        measure_div(3, "div by 3");
        write_reg(1'b0, `FM_REG_CLK_N2, 8'h00);
        measure_div(2, "div by 2");

        busy_test;
        chan_store_test;

        for (i = 0; i < 6; i++)
            key_write(i, 4'hF);
        key_write(1, 4'h0);
        key_write(4, 4'h0);
        key_write(4, 4'h2);     // one operator bit is enough

        write_reg(1'b0, `FM_REG_CLKA1, VAL_A[9:2]);
        write_reg(1'b0, `FM_REG_CLKA2, {6'b0, VAL_A[1:0]});
        write_reg(1'b0, `FM_REG_TIMER, 8'h05);     // load and enable A
        timer_period(1'b0, 8'h15, 1024 - VAL_A, "timer A period");

        write_reg(1'b0, `FM_REG_CLKB, VAL_B);
        write_reg(1'b0, `FM_REG_TIMER, 8'h1A);     // stop A, clear it, start B
        timer_period(1'b1, 8'h2A, `FM_TB_PRESCALE * (256 - VAL_B), "timer B period");
        write_reg(1'b0, `FM_REG_TIMER, 8'h20);
        repeat (2) @(negedge clk);
        check("flag_b cleared", 0, flag_b);
        check("irq_n released", 1, irq_n);

        if (fm_top_inst.fm_chk_inst.assert_fail) begin
            fail_run("a bound port assertion failed");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== fm_top.f ====
+incdir+design
design/fm_pkg.sv
design/fm_clk_div.sv
design/fm_mmr.sv
design/fm_chan_regs.sv
design/fm_timers.sv
design/fm_top.sv
tb/fm_tb_clk.sv
tb/fm_chk.sv
tb/fm_tb.sv
